// ==== Bender.yml ====
package:
  name: audio_fx

sources:
  - rtl/audio_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/audio_cfg_regs.sv
  - rtl/tone_gen.sv
  - rtl/clip_player.sv
  - rtl/audio_mixer.sv
  - rtl/audio_fx_top.sv
  - target: test
    files:
      - testbench/tb_audio_fx.sv

// ==== list.f ====
rtl/audio_pkg.sv
rtl/ctrl_pkg.sv
rtl/audio_cfg_regs.sv
rtl/tone_gen.sv
rtl/clip_player.sv
rtl/audio_mixer.sv
rtl/audio_fx_top.sv
testbench/tb_audio_fx.sv

// ==== rtl/audio_cfg_regs.sv ====
module audio_cfg_regs (
	input  logic                clk,
	input  logic                resetn,
	input  logic                cfg_req,
	input  ctrl_pkg::cfg_req_t  cfg,
	output logic                cfg_ack,
	output ctrl_pkg::cfg_t      fx_cfg,
	output logic                clip_start,
	output logic                tone_restart
);

	import ctrl_pkg::*;

	logic wr_en;

	// New request seen, ack not yet given
	assign wr_en = cfg_req && !cfg_ack;

	// Ack follows req by one cycle in both directions
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg_ack <= 1'b0;
		end else begin
			cfg_ack <= cfg_req;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			fx_cfg       <= '0;
			clip_start   <= 1'b0;
			tone_restart <= 1'b0;
		end else begin
			clip_start   <= 1'b0;
			tone_restart <= 1'b0;
			if (wr_en) begin
				case (cfg.addr)
					REG_TONE_PERIOD: begin
						fx_cfg.tone_period <= cfg.data[3:0];
						tone_restart       <= 1'b1;
					end
					REG_TONE_AMP: begin
						fx_cfg.tone_amp <= cfg.data[30:0];
					end
					REG_CLIP_GAIN: begin
						fx_cfg.clip_gain <= cfg.data[3:0];
					end
					REG_CLIP_TRIGGER: begin
						clip_start <= 1'b1;
					end
					// Unknown address is acked and dropped
					default: begin
					end
				endcase
			end
		end
	end

	// Handshake ordering
	ack_needs_req: assert property (
		@(posedge clk) disable iff (!resetn)
		$rose(cfg_ack) |-> cfg_req
	) else $error("cfg_ack rose without a pending cfg_req");

endmodule

// ==== rtl/audio_fx_top.sv ====
module audio_fx_top (
	input  logic                clk,
	input  logic                resetn,
	input  logic                cfg_req,
	input  ctrl_pkg::cfg_req_t  cfg,
	output logic                cfg_ack,
	input  logic                in_available,
	input  audio_pkg::stereo_t  sample_in,
	output logic                read_in,
	input  logic                out_allowed,
	output audio_pkg::stereo_t  sample_out,
	output logic                write_out,
	output logic                clip_busy
);

	import audio_pkg::*;
	import ctrl_pkg::*;

	cfg_t    fx_cfg;
	logic    clip_start;
	logic    tone_restart;
	logic    sample_tick;
	sample_t tone;
	sample_t clip;

	audio_cfg_regs u_regs (
		.clk          (clk),
		.resetn       (resetn),
		.cfg_req      (cfg_req),
		.cfg          (cfg),
		.cfg_ack      (cfg_ack),
		.fx_cfg       (fx_cfg),
		.clip_start   (clip_start),
		.tone_restart (tone_restart)
	);

	tone_gen u_tone (
		.clk          (clk),
		.resetn       (resetn),
		.fx_cfg       (fx_cfg),
		.tone_restart (tone_restart),
		.sample_tick  (sample_tick),
		.tone         (tone)
	);

	clip_player u_clip (
		.clk          (clk),
		.resetn       (resetn),
		.fx_cfg       (fx_cfg),
		.clip_start   (clip_start),
		.sample_tick  (sample_tick),
		.clip         (clip),
		.clip_busy    (clip_busy)
	);

	audio_mixer u_mixer (
		.clk          (clk),
		.resetn       (resetn),
		.in_available (in_available),
		.sample_in    (sample_in),
		.out_allowed  (out_allowed),
		.tone         (tone),
		.clip         (clip),
		.read_in      (read_in),
		.write_out    (write_out),
		.sample_out   (sample_out),
		.sample_tick  (sample_tick)
	);

endmodule

// ==== rtl/audio_mixer.sv ====
module audio_mixer (
	input  logic                clk,
	input  logic                resetn,
	input  logic                in_available,
	input  audio_pkg::stereo_t  sample_in,
	input  logic                out_allowed,
	input  audio_pkg::sample_t  tone,
	input  audio_pkg::sample_t  clip,
	output logic                read_in,
	output logic                write_out,
	output audio_pkg::stereo_t  sample_out,
	output logic                sample_tick
);

	import audio_pkg::*;

	logic xfer;

	// Three-way sum, clamped to the 32-bit range
	function automatic sample_t sat_add(input sample_t a, input sample_t b, input sample_t c);
		logic signed [33:0] sum;
		sum = 34'(a) + 34'(b) + 34'(c);
		if (sum > 34'(SAMPLE_MAX)) begin
			return SAMPLE_MAX;
		end else if (sum < 34'(SAMPLE_MIN)) begin
			return SAMPLE_MIN;
		end else begin
			return sample_t'(sum);
		end
	endfunction

	// One sample moves only when both sides are ready
	assign xfer        = in_available && out_allowed;
	assign read_in     = xfer;
	assign write_out   = xfer;
	assign sample_tick = xfer;

	always_comb begin
		sample_out.left  = sat_add(sample_in.left, tone, clip);
		sample_out.right = sat_add(sample_in.right, tone, clip);
	end

	// Non-negative terms never wrap to a negative sum
	no_positive_wrap: assert property (
		@(posedge clk) disable iff (!resetn)
		write_out && !sample_in.left[31] && !tone[31] && !clip[31]
			|-> !sample_out.left[31]
	) else $error("positive sum wrapped to a negative sample");

endmodule

// ==== rtl/audio_pkg.sv ====
package audio_pkg;

	// One codec word per channel
	typedef logic signed [31:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Saturation limits for the mixer
	localparam sample_t SAMPLE_MAX = 32'sh7fff_ffff;
	localparam sample_t SAMPLE_MIN = 32'sh8000_0000;

	// Stored clip
	localparam int CLIP_LEN = 100;
	localparam int CLIP_ENTRY_W = 3;

	typedef logic [6:0] clip_idx_t;

	localparam clip_idx_t CLIP_LAST = clip_idx_t'(CLIP_LEN - 1);

endpackage

// ==== rtl/clip_player.sv ====
module clip_player (
	input  logic               clk,
	input  logic               resetn,
	input  ctrl_pkg::cfg_t     fx_cfg,
	input  logic               clip_start,
	input  logic               sample_tick,
	output audio_pkg::sample_t clip,
	output logic               clip_busy
);

	import audio_pkg::*;
	import ctrl_pkg::*;

	clip_state_e state;
	clip_idx_t   idx;
	logic [8:0]  idx_x3;
	logic [CLIP_ENTRY_W-1:0] entry;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= CLIP_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				CLIP_IDLE, CLIP_DONE: begin
					idx   <= '0;
					state <= clip_start ? CLIP_PLAY : CLIP_IDLE;
				end
				CLIP_PLAY: begin
					if (clip_start) begin
						// Retrigger restarts from the top
						idx <= '0;
					end else if (sample_tick) begin
						if (idx == CLIP_LAST) begin
							idx   <= '0;
							state <= CLIP_DONE;
						end else begin
							idx <= idx + clip_idx_t'(1);
						end
					end
				end
				default: begin
					state <= CLIP_IDLE;
				end
			endcase
		end
	end

	// Table rule: entry k is 3k mod 8
	assign idx_x3 = {2'b00, idx} * 9'd3;
	assign entry  = idx_x3[CLIP_ENTRY_W-1:0];

	always_comb begin
		if (state == CLIP_PLAY) begin
			clip = sample_t'(entry) <<< fx_cfg.clip_gain;
		end else begin
			clip = '0;
		end
	end

	assign clip_busy = (state == CLIP_PLAY);

	idx_in_range: assert property (
		@(posedge clk) disable iff (!resetn)
		state == CLIP_PLAY |-> idx < CLIP_LEN
	) else $error("clip index ran past the table");

endmodule

// ==== rtl/ctrl_pkg.sv ====
package ctrl_pkg;

	// Host-visible register map
	typedef enum logic [31:0] {
		REG_TONE_PERIOD  = 32'd0,
		REG_TONE_AMP     = 32'd1,
		REG_CLIP_GAIN    = 32'd2,
		REG_CLIP_TRIGGER = 32'd3
	} cfg_addr_e;

	typedef struct packed {
		cfg_addr_e   addr;
		logic [31:0] data;
	} cfg_req_t;

	// Settings shared by the tone and clip sources
	typedef struct packed {
		logic [3:0]  tone_period;
		logic [30:0] tone_amp;
		logic [3:0]  clip_gain;
	} cfg_t;

	typedef enum logic [1:0] {
		CLIP_IDLE = 2'd0,
		CLIP_PLAY = 2'd1,
		CLIP_DONE = 2'd2
	} clip_state_e;

endpackage

// ==== rtl/tone_gen.sv ====
module tone_gen (
	input  logic              clk,
	input  logic              resetn,
	input  ctrl_pkg::cfg_t    fx_cfg,
	input  logic              tone_restart,
	input  logic              sample_tick,
	output audio_pkg::sample_t tone
);

	import audio_pkg::*;

	logic [3:0] sample_cnt;
	logic       phase_pos;
	sample_t    amp;

	// Counter and phase step once per transferred sample
	always_ff @(posedge clk) begin
		if (!resetn || tone_restart) begin
			sample_cnt <= '0;
			phase_pos  <= 1'b1;
		end else if (sample_tick && fx_cfg.tone_period != '0) begin
			if (sample_cnt == fx_cfg.tone_period - 4'd1) begin
				sample_cnt <= '0;
				phase_pos  <= !phase_pos;
			end else begin
				sample_cnt <= sample_cnt + 4'd1;
			end
		end
	end

	assign amp = sample_t'({1'b0, fx_cfg.tone_amp});

	always_comb begin
		if (fx_cfg.tone_period == '0) begin
			tone = '0;
		end else if (phase_pos) begin
			tone = amp;
		end else begin
			tone = -amp;
		end
	end

endmodule

// ==== testbench/audio_fx_tests.txt ====
# WR   name addr data                              (hex)
# SMP  name count in_l in_r exp_l exp_r            (count decimal, rest hex, exp without clip)
# BUSY name clip_busy
BUSY reset_idle 0
SMP pass_small 1 00001234 ffffedcc 00001234 ffffedcc
SMP pass_limits 3 7fffffff 80000000 7fffffff 80000000
WR amp_set 00000001 000003e8
SMP amp_no_period 2 00000010 00000020 00000010 00000020
WR period_set 00000000 00000003
SMP tone_pos1 3 00000100 00000200 000004e8 000005e8
SMP tone_neg1 3 00000100 00000200 fffffd18 fffffe18
SMP tone_pos2 2 00000100 00000200 000004e8 000005e8
WR period_rewrite 00000000 00000003
SMP tone_pos3 3 00000100 00000200 000004e8 000005e8
SMP tone_neg2 1 00000100 00000200 fffffd18 fffffe18
WR bad_addr 00000007 deadbeef
SMP tone_neg3 2 00000100 00000200 fffffd18 fffffe18
SMP tone_pos4 1 00000100 00000200 000004e8 000005e8
WR amp_big 00000001 40000000
SMP sat_pos 2 7fff0000 40000000 7fffffff 7fffffff
SMP sat_neg 3 80010000 c0000000 80000000 80000000
WR tone_off 00000000 00000000
SMP off_pass 2 00000055 00000066 00000055 00000066
WR clip_gain 00000002 00000002
WR clip_go 00000003 00000001
BUSY clip_on 1
SMP clip_play 99 00000010 fffffff0 00000010 fffffff0
BUSY clip_still_on 1
SMP clip_last 1 00000010 fffffff0 00000010 fffffff0
BUSY clip_off 0
SMP after_clip 2 00000010 fffffff0 00000010 fffffff0
WR clip_go2 00000003 00000001
SMP clip_part 40 00000020 00000030 00000020 00000030
WR clip_retrig 00000003 00000000
SMP clip_replay 100 00000020 00000030 00000020 00000030
BUSY clip_end 0

// ==== testbench/tb_audio_fx.sv ====
module tb_audio_fx;

	import audio_pkg::*;
	import ctrl_pkg::*;

	localparam string TEST_FILE = "testbench/audio_fx_tests.txt";
	localparam int ACK_LIMIT = 8;
	localparam int CYCLES_PER_LINE = 200;

	logic     clk;
	logic     resetn;
	logic     cfg_req;
	cfg_req_t cfg;
	logic     cfg_ack;
	logic     in_available;
	stereo_t  sample_in;
	logic     read_in;
	logic     out_allowed;
	stereo_t  sample_out;
	logic     write_out;
	logic     clip_busy;

	string       lines[$];
	bit          loaded;

	// Expected clip position, kept from the table rule
	bit         clip_on;
	int         clip_k;
	logic [3:0] clip_gain_m;

	audio_fx_top dut (
		.clk          (clk),
		.resetn       (resetn),
		.cfg_req      (cfg_req),
		.cfg          (cfg),
		.cfg_ack      (cfg_ack),
		.in_available (in_available),
		.sample_in    (sample_in),
		.read_in      (read_in),
		.out_allowed  (out_allowed),
		.sample_out   (sample_out),
		.write_out    (write_out),
		.clip_busy    (clip_busy)
	);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_stereo(input string name, input stereo_t exp, input stereo_t act);
		if (act !== exp) begin
			$display("** Error %s: expected %h/%h, actual %h/%h",
				name, exp.left, exp.right, act.left, act.right);
			stop_run();
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: expected clip_busy %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_strobe(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_fields(input string line, input int got, input int want);
		if (got != want) begin
			$display("Test file line has %0d fields instead of %0d: %s", got, want, line);
			stop_run();
		end
	endtask

	task automatic load_tests();
		int    fd;
		string line;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the test file %s", TEST_FILE);
			stop_run();
		end
		while ($fgets(line, fd) != 0) begin
			// Skip blank lines and the column notes
			if (line.len() > 1 && line.getc(0) != "#") begin
				lines.push_back(line);
			end
		end
		$fclose(fd);
	endtask

	task automatic wait_ack(input string name, input logic level);
		int waited;
		waited = 0;
		@(negedge clk);
		while (cfg_ack !== level) begin
			if (waited == ACK_LIMIT) begin
				$display("Test %s: cfg_ack did not go %b after cfg_req changed", name, level);
				stop_run();
			end
			waited++;
			@(negedge clk);
		end
	endtask

	// Full four-phase register write
	task automatic write_reg(input string name, input logic [31:0] addr, input logic [31:0] data);
		cfg_req_t req;
		req.addr = cfg_addr_e'(addr);
		req.data = data;
		@(posedge clk);
		in_available <= 1'b0;
		out_allowed  <= 1'b0;
		cfg          <= req;
		cfg_req      <= 1'b1;
		wait_ack(name, 1'b1);
		@(posedge clk);
		cfg_req <= 1'b0;
		wait_ack(name, 1'b0);
	endtask

	task automatic send_sample(input string name, input sample_t in_l, input sample_t in_r,
			input sample_t exp_l, input sample_t exp_r);
		stereo_t s_in;
		stereo_t s_exp;
		sample_t term;
		int      gap;
		term = clip_on ? sample_t'(((3 * clip_k) % 8) << clip_gain_m) : '0;
		s_in.left   = in_l;
		s_in.right  = in_r;
		s_exp.left  = exp_l + term;
		s_exp.right = exp_r + term;
		gap = $urandom % 4;
		// Output side ready, nothing on the input side
		@(posedge clk);
		in_available <= 1'b0;
		out_allowed  <= 1'b1;
		@(negedge clk);
		check_strobe({name, " read_in while empty"}, 1'b0, read_in);
		check_strobe({name, " write_out while empty"}, 1'b0, write_out);
		// Data waits while the output side stalls
		repeat (gap) begin
			@(posedge clk);
			in_available <= 1'b1;
			out_allowed  <= 1'b0;
			sample_in    <= s_in;
			@(negedge clk);
			check_strobe({name, " read_in in gap"}, 1'b0, read_in);
			check_strobe({name, " write_out in gap"}, 1'b0, write_out);
		end
		@(posedge clk);
		in_available <= 1'b1;
		out_allowed  <= 1'b1;
		sample_in    <= s_in;
		@(negedge clk);
		check_strobe({name, " read_in"}, 1'b1, read_in);
		check_strobe({name, " write_out"}, 1'b1, write_out);
		check_stereo(name, s_exp, sample_out);
		if (clip_on) begin
			clip_k++;
			if (clip_k == CLIP_LEN) begin
				clip_on = 1'b0;
			end
		end
	endtask

	task automatic run_line(input string line);
		string       kind;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		int          count;
		int          n;
		n = $sscanf(line, "%s %s", kind, name);
		check_fields(line, n, 2);
		if (kind == "WR") begin
			n = $sscanf(line, "%s %s %h %h", kind, name, a, b);
			check_fields(line, n, 4);
			write_reg(name, a, b);
			if (a == 32'(REG_CLIP_TRIGGER)) begin
				clip_on = 1'b1;
				clip_k  = 0;
			end else if (a == 32'(REG_CLIP_GAIN)) begin
				clip_gain_m = b[3:0];
			end
		end else if (kind == "SMP") begin
			n = $sscanf(line, "%s %s %d %h %h %h %h", kind, name, count, a, b, c, d);
			check_fields(line, n, 7);
			repeat (count) begin
				send_sample(name, a, b, c, d);
			end
		end else if (kind == "BUSY") begin
			n = $sscanf(line, "%s %s %h", kind, name, a);
			check_fields(line, n, 3);
			@(posedge clk);
			in_available <= 1'b0;
			out_allowed  <= 1'b0;
			@(negedge clk);
			check_busy(name, a[0], clip_busy);
		end else begin
			$display("Unknown line in the test file: %s", line);
			stop_run();
		end
	endtask

	// Watchdog sized from the number of test lines
	initial begin
		wait (loaded);
		repeat (lines.size() * CYCLES_PER_LINE) @(posedge clk);
		$display("Run did not finish within %0d cycles", lines.size() * CYCLES_PER_LINE);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		resetn       = 1'b0;
		cfg_req      = 1'b0;
		cfg          = '0;
		in_available = 1'b0;
		sample_in    = '0;
		out_allowed  = 1'b0;
		clip_on      = 1'b0;
		clip_k       = 0;
		clip_gain_m  = '0;
		void'($urandom(32'hc87f2f64));
		load_tests();
		loaded = 1'b1;
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_strobe("reset cfg_ack", 1'b0, cfg_ack);
		check_strobe("reset read_in", 1'b0, read_in);
		check_strobe("reset write_out", 1'b0, write_out);
		check_busy("reset clip_busy", 1'b0, clip_busy);
		@(posedge clk);
		resetn <= 1'b1;
		foreach (lines[i]) begin
			run_line(lines[i]);
		end
		@(posedge clk);
		in_available <= 1'b0;
		out_allowed  <= 1'b0;
		@(negedge clk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule
